// ==== Bender.yml ====
package:
  name: chacha

sources:
  - chacha_pkg.sv
  - chacha_qr.sv
  - chacha_regs.sv
  - chacha_core.sv
  - chacha_result.sv
  - chacha.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_chacha.sv

// ==== chacha.sv ====
`timescale 1ns/1ps

module chacha #(
  parameter chacha_pkg::rounds_t DEFAULT_ROUNDS = 5'd20
) (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  logic              cs,
  input  logic              we,
  input  chacha_pkg::addr_t addr,
  input  chacha_pkg::word_t write_data,
  output chacha_pkg::word_t read_data
);

  import chacha_pkg::*;

  // ------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------
  // configuration from the register block
  key_t    key;
  word_t   ctr;
  nonce_t  nonce;
  rounds_t rounds;
  block_t  data_in;
  logic    init;

  // core to result side
  logic    ready;
  block_t  keystream;
  logic    keystream_valid;

  // bus writes
  chacha_regs #(
    .DEFAULT_ROUNDS (DEFAULT_ROUNDS)
  ) u_regs (
    .tb_clk     (tb_clk),
    .rst_n      (rst_n),
    .cs         (cs),
    .we         (we),
    .addr       (addr),
    .write_data (write_data),
    .key        (key),
    .ctr        (ctr),
    .nonce      (nonce),
    .rounds     (rounds),
    .data_in    (data_in),
    .init       (init)
  );

  // block function
  chacha_core u_core (
    .tb_clk          (tb_clk),
    .rst_n           (rst_n),
    .init            (init),
    .key             (key),
    .ctr             (ctr),
    .nonce           (nonce),
    .rounds          (rounds),
    .ready           (ready),
    .keystream       (keystream),
    .keystream_valid (keystream_valid)
  );

  // xor and bus reads
  chacha_result u_result (
    .tb_clk          (tb_clk),
    .rst_n           (rst_n),
    .cs              (cs),
    .we              (we),
    .addr            (addr),
    .data_in         (data_in),
    .keystream       (keystream),
    .keystream_valid (keystream_valid),
    .ready           (ready),
    .read_data       (read_data)
  );

endmodule

// ==== chacha_core.sv ====
`timescale 1ns/1ps

module chacha_core (
  input  logic                tb_clk,
  input  logic                rst_n,
  input  logic                init,
  input  chacha_pkg::key_t    key,
  input  chacha_pkg::word_t   ctr,
  input  chacha_pkg::nonce_t  nonce,
  input  chacha_pkg::rounds_t rounds,
  output logic                ready,
  output chacha_pkg::block_t  keystream,
  output logic                keystream_valid
);

  import chacha_pkg::*;

  core_state_e fsm_state;
  // round counter and even round total for this run
  rounds_t     round_ctr;
  rounds_t     n_rounds;
  logic        diag;

  // working state and the copy kept for the final add
  word_t work_state  [16];
  word_t start_state [16];
  word_t load_state  [16];
  word_t round_state [16];

  // quarter round outputs
  word_t qa_out [4];
  word_t qb_out [4];
  word_t qc_out [4];
  word_t qd_out [4];

  // little endian word from big endian bus order
  function automatic word_t bswap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // ------------------------------------------------------------
  // initial state
  // ------------------------------------------------------------
  always_comb
  begin
    load_state[0] = CHACHA_CONST0;
    load_state[1] = CHACHA_CONST1;
    load_state[2] = CHACHA_CONST2;
    load_state[3] = CHACHA_CONST3;
    for (int i = 0; i < 8; i++)
    begin
      load_state[4 + i] = bswap(key[255 - 32*i -: 32]);
    end
    // counter goes in unswapped
    load_state[12] = ctr;
    for (int i = 0; i < 3; i++)
    begin
      load_state[13 + i] = bswap(nonce[95 - 32*i -: 32]);
    end
  end

  // ------------------------------------------------------------
  // quarter rounds
  // ------------------------------------------------------------
  // even cycles columns, odd cycles diagonals
  assign diag = round_ctr[0];

  for (genvar g = 0; g < 4; g++)
  begin : g_qr
    localparam int DB = 4 + ((g + 1) % 4);
    localparam int DC = 8 + ((g + 2) % 4);
    localparam int DD = 12 + ((g + 3) % 4);

    chacha_qr u_qr (
      .a_in  (work_state[g]),
      .b_in  (diag ? work_state[DB] : work_state[4 + g]),
      .c_in  (diag ? work_state[DC] : work_state[8 + g]),
      .d_in  (diag ? work_state[DD] : work_state[12 + g]),
      .a_out (qa_out[g]),
      .b_out (qb_out[g]),
      .c_out (qc_out[g]),
      .d_out (qd_out[g])
    );
  end

  // write back along the same routing
  always_comb
  begin
    round_state = work_state;
    for (int i = 0; i < 4; i++)
    begin
      round_state[i] = qa_out[i];
      if (diag)
      begin
        round_state[4 + ((i + 1) % 4)]  = qb_out[i];
        round_state[8 + ((i + 2) % 4)]  = qc_out[i];
        round_state[12 + ((i + 3) % 4)] = qd_out[i];
      end
      else
      begin
        round_state[4 + i]  = qb_out[i];
        round_state[8 + i]  = qc_out[i];
        round_state[12 + i] = qd_out[i];
      end
    end
  end

  // ------------------------------------------------------------
  // control FSM
  // ------------------------------------------------------------
  always_ff @(posedge tb_clk)
  begin
    if (!rst_n)
    begin
      fsm_state <= IDLE;
      ready     <= 1'b1;
      round_ctr <= '0;
      n_rounds  <= '0;
    end
    else
    begin
      case (fsm_state)
        IDLE:
        begin
          // ready is high only here, so init is ignored while busy
          if (init)
          begin
            fsm_state <= LOAD;
            ready     <= 1'b0;
          end
        end
        LOAD:
        begin
          // low bit of rounds dropped
          n_rounds  <= {rounds[4:1], 1'b0};
          round_ctr <= '0;
          fsm_state <= (rounds[4:1] == 4'd0) ? FINISH : ROUND;
        end
        ROUND:
        begin
          round_ctr <= round_ctr + 5'd1;
          if (round_ctr == n_rounds - 5'd1)
          begin
            fsm_state <= FINISH;
          end
        end
        default:
        begin
          fsm_state <= IDLE;
          ready     <= 1'b1;
        end
      endcase
    end
  end

  // cipher state loaded in LOAD and updated per round
  always_ff @(posedge tb_clk)
  begin
    if (fsm_state == LOAD)
    begin
      work_state  <= load_state;
      start_state <= load_state;
    end
    else if (fsm_state == ROUND)
    begin
      work_state <= round_state;
    end
  end

  // ------------------------------------------------------------
  // keystream out
  // ------------------------------------------------------------
  // valid strobe only in FINISH
  assign keystream_valid = (fsm_state == FINISH);

  always_comb
  begin
    for (int i = 0; i < 16; i++)
    begin
      keystream[511 - 32*i -: 32] = bswap(work_state[i] + start_state[i]);
    end
  end

endmodule

// ==== chacha_pkg.sv ====
package chacha_pkg;

  // ------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------

  // one bus or state word
  typedef logic [31:0]  word_t;
  typedef logic [7:0]   addr_t;
  // round count field, low bit ignored by the core
  typedef logic [4:0]   rounds_t;
  // word 0 sits in the top bits for all wide types
  typedef logic [255:0] key_t;
  typedef logic [95:0]  nonce_t;
  typedef logic [511:0] block_t;

  // core FSM
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    ROUND,
    FINISH
  } core_state_e;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------
  localparam addr_t ADDR_CTRL      = 8'h08;
  localparam addr_t ADDR_STATUS    = 8'h09;
  localparam addr_t ADDR_ROUNDS    = 8'h0b;
  localparam addr_t ADDR_KEY0      = 8'h10;
  localparam addr_t ADDR_CTR       = 8'h18;
  localparam addr_t ADDR_IV0       = 8'h20;
  localparam addr_t ADDR_DATA_IN0  = 8'h40;
  localparam addr_t ADDR_DATA_OUT0 = 8'h80;

  // "expand 32-byte k" as little endian words
  localparam word_t CHACHA_CONST0 = 32'h61707865;
  localparam word_t CHACHA_CONST1 = 32'h3320646e;
  localparam word_t CHACHA_CONST2 = 32'h79622d32;
  localparam word_t CHACHA_CONST3 = 32'h6b206574;

endpackage

// ==== chacha_qr.sv ====
`timescale 1ns/1ps

module chacha_qr (
  input  chacha_pkg::word_t a_in,
  input  chacha_pkg::word_t b_in,
  input  chacha_pkg::word_t c_in,
  input  chacha_pkg::word_t d_in,
  output chacha_pkg::word_t a_out,
  output chacha_pkg::word_t b_out,
  output chacha_pkg::word_t c_out,
  output chacha_pkg::word_t d_out
);

  import chacha_pkg::*;

  // add, xor, rotate chain
  always_comb
  begin
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    a = a_in + b_in;
    d = d_in ^ a;
    d = {d[15:0], d[31:16]};
    c = c_in + d;
    b = b_in ^ c;
    b = {b[19:0], b[31:20]};
    // second half, rotates by 8 and 7
    a = a + b;
    d = d ^ a;
    d = {d[23:0], d[31:24]};
    c = c + d;
    b = b ^ c;
    b = {b[24:0], b[31:25]};
    a_out = a;
    b_out = b;
    c_out = c;
    d_out = d;
  end

endmodule

// ==== chacha_regs.sv ====
`timescale 1ns/1ps

module chacha_regs #(
  parameter chacha_pkg::rounds_t DEFAULT_ROUNDS = 5'd20
) (
  input  logic                tb_clk,
  input  logic                rst_n,
  input  logic                cs,
  input  logic                we,
  input  chacha_pkg::addr_t   addr,
  input  chacha_pkg::word_t   write_data,
  output chacha_pkg::key_t    key,
  output chacha_pkg::word_t   ctr,
  output chacha_pkg::nonce_t  nonce,
  output chacha_pkg::rounds_t rounds,
  output chacha_pkg::block_t  data_in,
  output logic                init
);

  import chacha_pkg::*;

  // configuration and plaintext storage
  word_t key_reg   [8];
  word_t nonce_reg [3];
  word_t data_reg  [16];
  word_t ctr_reg;

  logic  wr_en;
  logic  hit_key;
  logic  hit_iv;
  logic  hit_data;

  // ------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------
  assign wr_en    = cs && we;
  // eight key words at 0x10..0x17
  assign hit_key  = (addr[7:3] == ADDR_KEY0[7:3]);
  // three nonce words, 0x23 is unused
  assign hit_iv   = (addr[7:2] == ADDR_IV0[7:2]) && (addr[1:0] != 2'b11);
  assign hit_data = (addr[7:4] == ADDR_DATA_IN0[7:4]);

  // control state: rounds and the init strobe
  always_ff @(posedge tb_clk)
  begin
    if (!rst_n)
    begin
      rounds <= DEFAULT_ROUNDS;
      init   <= 1'b0;
    end
    else
    begin
      // one cycle pulse, ctrl itself keeps nothing
      init <= wr_en && (addr == ADDR_CTRL) && write_data[0];
      if (wr_en && (addr == ADDR_ROUNDS))
      begin
        rounds <= write_data[4:0];
      end
    end
  end

  // payload registers
  always_ff @(posedge tb_clk)
  begin
    if (wr_en)
    begin
      if (hit_key)
      begin
        key_reg[addr[2:0]] <= write_data;
      end
      if (addr == ADDR_CTR)
      begin
        ctr_reg <= write_data;
      end
      if (hit_iv)
      begin
        nonce_reg[addr[1:0]] <= write_data;
      end
      if (hit_data)
      begin
        data_reg[addr[3:0]] <= write_data;
      end
    end
  end

  // ------------------------------------------------------------
  // pack word arrays, word 0 on top
  // ------------------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < 8; i++)
    begin
      key[255 - 32*i -: 32] = key_reg[i];
    end
    for (int i = 0; i < 3; i++)
    begin
      nonce[95 - 32*i -: 32] = nonce_reg[i];
    end
    for (int i = 0; i < 16; i++)
    begin
      data_in[511 - 32*i -: 32] = data_reg[i];
    end
  end

  assign ctr = ctr_reg;

endmodule

// ==== chacha_result.sv ====
`timescale 1ns/1ps

module chacha_result (
  input  logic               tb_clk,
  input  logic               rst_n,
  input  logic               cs,
  input  logic               we,
  input  chacha_pkg::addr_t  addr,
  input  chacha_pkg::block_t data_in,
  input  chacha_pkg::block_t keystream,
  input  logic               keystream_valid,
  input  logic               ready,
  output chacha_pkg::word_t  read_data
);

  import chacha_pkg::*;

  // result words, kept until the next completion
  word_t result_word [16];
  logic  rd_en;

  assign rd_en = cs && !we;

  // ------------------------------------------------------------
  // result latch
  // ------------------------------------------------------------
  // cleared so DATA_OUT reads zero before the first run
  always_ff @(posedge tb_clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 16; i++)
      begin
        result_word[i] <= '0;
      end
    end
    else if (keystream_valid)
    begin
      for (int i = 0; i < 16; i++)
      begin
        result_word[i] <= data_in[511 - 32*i -: 32] ^ keystream[511 - 32*i -: 32];
      end
    end
  end

  // ------------------------------------------------------------
  // read port
  // ------------------------------------------------------------
  // value held until the next read
  always_ff @(posedge tb_clk)
  begin
    if (!rst_n)
    begin
      read_data <= '0;
    end
    else if (rd_en)
    begin
      if (addr == ADDR_STATUS)
      begin
        read_data <= {31'd0, ready};
      end
      else if (addr[7:4] == ADDR_DATA_OUT0[7:4])
      begin
        read_data <= result_word[addr[3:0]];
      end
      else
      begin
        // config registers are write only
        read_data <= '0;
      end
    end
  end

endmodule

// ==== src.f ====
+incdir+.
chacha_pkg.sv
chacha_qr.sv
chacha_regs.sv
chacha_core.sv
chacha_result.sv
chacha.sv
tb_chacha.sv

// ==== tb_chacha_model.svh ====
`ifndef TB_CHACHA_MODEL_SVH
`define TB_CHACHA_MODEL_SVH

// ------------------------------------------------------------
// reference model of the keystream
// ------------------------------------------------------------

// left rotate of one word
function automatic word_t model_rotl(input word_t x, input int n);
  return (x << n) | (x >> (32 - n));
endfunction

// reverse byte order of one word
function automatic word_t model_byte_rev(input word_t w);
  return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// quarter round, returns {a, b, c, d}
function automatic logic [127:0] model_quarter(input word_t a, input word_t b,
                                                input word_t c, input word_t d);
  a = a + b;
  d = model_rotl(d ^ a, 16);
  c = c + d;
  b = model_rotl(b ^ c, 12);
  a = a + b;
  d = model_rotl(d ^ a, 8);
  c = c + d;
  b = model_rotl(b ^ c, 7);
  return {a, b, c, d};
endfunction

// full block function, word 0 of the result in the top bits
function automatic block_t model_keystream(input key_t key, input word_t ctr,
                                           input nonce_t nonce, input rounds_t rounds);
  word_t  init_s [16];
  word_t  x      [16];
  block_t ks;
  int     n_double;
  // "expand 32-byte k"
  init_s[0] = 32'h61707865;
  init_s[1] = 32'h3320646e;
  init_s[2] = 32'h79622d32;
  init_s[3] = 32'h6b206574;
  for (int i = 0; i < 8; i++)
  begin
    init_s[4 + i] = model_byte_rev(key[255 - 32*i -: 32]);
  end
  // block counter taken as is
  init_s[12] = ctr;
  for (int i = 0; i < 3; i++)
  begin
    init_s[13 + i] = model_byte_rev(nonce[95 - 32*i -: 32]);
  end
  x = init_s;
  // odd round counts lose their last round
  n_double = int'(rounds) / 2;
  for (int r = 0; r < n_double; r++)
  begin
    // columns
    {x[0], x[4], x[8], x[12]}  = model_quarter(x[0], x[4], x[8], x[12]);
    {x[1], x[5], x[9], x[13]}  = model_quarter(x[1], x[5], x[9], x[13]);
    {x[2], x[6], x[10], x[14]} = model_quarter(x[2], x[6], x[10], x[14]);
    {x[3], x[7], x[11], x[15]} = model_quarter(x[3], x[7], x[11], x[15]);
    // diagonals
    {x[0], x[5], x[10], x[15]} = model_quarter(x[0], x[5], x[10], x[15]);
    {x[1], x[6], x[11], x[12]} = model_quarter(x[1], x[6], x[11], x[12]);
    {x[2], x[7], x[8], x[13]}  = model_quarter(x[2], x[7], x[8], x[13]);
    {x[3], x[4], x[9], x[14]}  = model_quarter(x[3], x[4], x[9], x[14]);
  end
  for (int i = 0; i < 16; i++)
  begin
    ks[511 - 32*i -: 32] = model_byte_rev(x[i] + init_s[i]);
  end
  return ks;
endfunction

`endif

// ==== tb_chacha.sv ====
`timescale 1ns/1ps

module tb_chacha;

  import chacha_pkg::*;

  `include "tb_chacha_model.svh"

  // ------------------------------------------------------------
  // run length budget
  // ------------------------------------------------------------
  localparam int NUM_TESTS   = 6;
  localparam int BUS_CYCLES  = 60;
  localparam int CORE_CYCLES = 30;
  // two clocks per bus access, then doubled for margin
  localparam int CYCLE_LIMIT = 2 * NUM_TESTS * (2 * BUS_CYCLES + CORE_CYCLES);

  logic  tb_clk;
  logic  rst_n;
  logic  cs;
  logic  we;
  addr_t addr;
  word_t write_data;
  word_t read_data;

  // bookkeeping
  int error_count;
  int check_count;
  int test_count;
  int test_start_errors;
  int cycle_count;

  chacha #(
    .DEFAULT_ROUNDS (5'd20)
  ) u_dut (
    .tb_clk     (tb_clk),
    .rst_n      (rst_n),
    .cs         (cs),
    .we         (we),
    .addr       (addr),
    .write_data (write_data),
    .read_data  (read_data)
  );

  // 8 ns clock
  initial
  begin
    tb_clk = 1'b0;
    forever #4 tb_clk = ~tb_clk;
  end

  // watchdog on clock cycles
  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge tb_clk);
      cycle_count++;
    end
    $display("timeout, run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("test failed");
    $finish;
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_block(input string name, input block_t got, input block_t exp);
    check_count++;
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%0128h, expected 0x%0128h", name, got, exp);
      error_count++;
    end
  endtask

  // ------------------------------------------------------------
  // bus access, driven on falling edges
  // ------------------------------------------------------------
  task automatic write_word(input addr_t a, input word_t d);
    @(negedge tb_clk);
    cs         = 1'b1;
    we         = 1'b1;
    addr       = a;
    write_data = d;
    @(negedge tb_clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  // read data sampled half a cycle after the capturing edge
  task automatic read_word(input addr_t a, output word_t d);
    @(negedge tb_clk);
    cs   = 1'b1;
    we   = 1'b0;
    addr = a;
    @(negedge tb_clk);
    cs = 1'b0;
    d  = read_data;
  endtask

  // poll status until ready, at most 100 reads
  task automatic wait_ready();
    word_t status;
    int    polls;
    status = '0;
    polls  = 0;
    while (status[0] !== 1'b1 && polls < 100)
    begin
      read_word(ADDR_STATUS, status);
      polls++;
    end
    if (status[0] !== 1'b1)
    begin
      $display("ready never returned to 1 within 100 status reads");
      error_count++;
    end
  endtask

  // key, counter, nonce, rounds and plaintext
  task automatic load_config(input key_t k, input word_t c, input nonce_t n,
                             input rounds_t r, input block_t p);
    for (int i = 0; i < 8; i++)
    begin
      write_word(addr_t'(ADDR_KEY0 + i), k[255 - 32*i -: 32]);
    end
    write_word(ADDR_CTR, c);
    for (int i = 0; i < 3; i++)
    begin
      write_word(addr_t'(ADDR_IV0 + i), n[95 - 32*i -: 32]);
    end
    write_word(ADDR_ROUNDS, {27'd0, r});
    for (int i = 0; i < 16; i++)
    begin
      write_word(addr_t'(ADDR_DATA_IN0 + i), p[511 - 32*i -: 32]);
    end
  endtask

  task automatic read_result(output block_t res);
    word_t w;
    for (int i = 0; i < 16; i++)
    begin
      read_word(addr_t'(ADDR_DATA_OUT0 + i), w);
      res[511 - 32*i -: 32] = w;
    end
  endtask

  // one full block, model_rounds may differ from the written count
  task automatic run_block(input string name, input key_t k, input word_t c,
                           input nonce_t n, input rounds_t r, input block_t p,
                           input rounds_t model_rounds);
    block_t got;
    block_t exp;
    load_config(k, c, n, r, p);
    write_word(ADDR_CTRL, 32'h1);
    wait_ready();
    read_result(got);
    exp = p ^ model_keystream(k, c, n, model_rounds);
    check_block(name, got, exp);
  endtask

  // ------------------------------------------------------------
  // random stimulus
  // ------------------------------------------------------------
  function automatic key_t rand_key();
    key_t k;
    for (int i = 0; i < 8; i++)
    begin
      k[255 - 32*i -: 32] = $urandom();
    end
    return k;
  endfunction

  function automatic nonce_t rand_nonce();
    return {$urandom(), $urandom(), $urandom()};
  endfunction

  function automatic block_t rand_block();
    block_t b;
    for (int i = 0; i < 16; i++)
    begin
      b[511 - 32*i -: 32] = $urandom();
    end
    return b;
  endfunction

  // one summary line per test
  task automatic end_test(input string name);
    test_count++;
    if (error_count == test_start_errors)
    begin
      $display("test %0d %s ok", test_count, name);
    end
    else
    begin
      $display("test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial
  begin
    key_t   k_a;
    key_t   k_b;
    word_t  w;
    cs                = 1'b0;
    we                = 1'b0;
    addr              = '0;
    write_data        = '0;
    rst_n             = 1'b0;
    error_count       = 0;
    check_count       = 0;
    test_count        = 0;
    test_start_errors = 0;
    void'($urandom(32'he4476ecf));
    repeat (4) @(posedge tb_clk);
    @(negedge tb_clk);
    rst_n = 1'b1;

    // reset values on the bus
    read_word(ADDR_STATUS, w);
    check_word("read_data at ADDR_STATUS", w, 32'h1);
    read_word(ADDR_DATA_OUT0, w);
    check_word("read_data at ADDR_DATA_OUT0", w, 32'h0);
    end_test("reset state");

    // ready drops after init, then comes back
    load_config(rand_key(), $urandom(), rand_nonce(), 5'd20, rand_block());
    write_word(ADDR_CTRL, 32'h1);
    read_word(ADDR_STATUS, w);
    check_word("read_data at ADDR_STATUS after init", w, 32'h0);
    wait_ready();
    end_test("ready handshake");

    run_block("result 20 rounds", rand_key(), $urandom(), rand_nonce(), 5'd20,
              rand_block(), 5'd20);
    end_test("random 20 rounds");

    run_block("result 8 rounds", rand_key(), $urandom(), rand_nonce(), 5'd8,
              rand_block(), 5'd8);
    run_block("result 12 rounds", rand_key(), $urandom(), rand_nonce(), 5'd12,
              rand_block(), 5'd12);
    end_test("8 and 12 rounds");

    // odd count behaves as one less
    run_block("result 9 rounds", rand_key(), $urandom(), rand_nonce(), 5'd9,
              rand_block(), 5'd8);
    end_test("odd round count");

    // second key forced to differ
    k_a    = rand_key();
    k_b    = rand_key();
    k_b[0] = ~k_a[0];
    run_block("result first key", k_a, $urandom(), rand_nonce(), 5'd20, rand_block(), 5'd20);
    run_block("result second key", k_b, $urandom(), rand_nonce(), 5'd20, rand_block(), 5'd20);
    read_word(ADDR_KEY0, w);
    check_word("read_data at ADDR_KEY0", w, 32'h0);
    end_test("back to back runs");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule
